//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

  localparam int TIMEOUT = 50;

  logic                clk;
  logic                rst;
  logic                refresh;
  mem_pkg::reg_t       ram_wr_src;
  mem_pkg::load_info_t load_info;
  mem_pkg::save_info_t save_info;
  mem_pkg::addr_t      mem_addr;
  logic                ram_rd_ena;
  logic                ram_wr_ena;
  logic                fetch_en;
  mem_pkg::reg_t       mem_data;
  mem_pkg::excp_t      mem_excp;
  logic                mem_fetched;
  mem_pkg::inst_t      inst;
  mem_pkg::addr_t      inst_pc;
  logic                inst_valid;

  logic [7:0]          ref_mem [2048]; // byte model of the RAM
  integer              seed = 29161;
  int                  drv_errors = 0;
  int                  drv_checks = 0;
  int                  cmp_errors = 0;
  int                  cmp_checks = 0;
  int                  err_mark;
  int                  inst_cnt = 0;
  string               cur_test;
  logic                pend_load = 1'b0;
  mem_pkg::load_info_t pend_info;
  mem_pkg::addr_t      pend_addr;
  mem_pkg::addr_t      exp_pc = '0;

  tb_clock_gen u_clk (.clk(clk), .rst(rst));

  mem_subsys_top uut (.*);

  function automatic logic [10:0] byte_idx(mem_pkg::addr_t addr, int i);
    mem_pkg::addr_t a;
    a = addr + mem_pkg::addr_t'(i);
    return a[10:0]; // 2 KiB wrap
  endfunction

  function automatic mem_pkg::load_info_t ld_hot(int k);
    mem_pkg::load_info_t v;
    v    = '0;
    v[k] = 1'b1;
    return v;
  endfunction

  function automatic mem_pkg::save_info_t st_hot(int nbytes);
    mem_pkg::save_info_t v;
    v = '0;
    case (nbytes)
      1:       v[mem_pkg::SAVE_SB] = 1'b1;
      2:       v[mem_pkg::SAVE_SH] = 1'b1;
      4:       v[mem_pkg::SAVE_SW] = 1'b1;
      default: v[mem_pkg::SAVE_SD] = 1'b1;
    endcase
    return v;
  endfunction

  function automatic mem_pkg::reg_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // reference load result from the byte model
  function automatic mem_pkg::reg_t expect_load(mem_pkg::load_info_t li, mem_pkg::addr_t addr);
    mem_pkg::reg_t val;
    int            nbytes;
    logic          sext;
    int            i;
    val    = '0;
    nbytes = 8;
    if (li[mem_pkg::LOAD_LB] || li[mem_pkg::LOAD_LBU]) nbytes = 1;
    if (li[mem_pkg::LOAD_LH] || li[mem_pkg::LOAD_LHU]) nbytes = 2;
    if (li[mem_pkg::LOAD_LW] || li[mem_pkg::LOAD_LWU]) nbytes = 4;
    sext = li[mem_pkg::LOAD_LB] || li[mem_pkg::LOAD_LH] || li[mem_pkg::LOAD_LW];
    for (i = 0; i < nbytes; i++) val[8*i +: 8] = ref_mem[byte_idx(addr, i)];
    if (sext && val[8*nbytes-1]) begin
      for (i = 8 * nbytes; i < 64; i++) val[i] = 1'b1;
    end
    return val;
  endfunction

  always @(negedge clk) begin : compare
    mem_pkg::reg_t  exp_data;
    mem_pkg::inst_t exp_inst;
    if (!rst && mem_fetched && pend_load) begin
      exp_data = expect_load(pend_info, pend_addr);
      cmp_checks++;
      assert (mem_data === exp_data) else begin
        $display("ERROR %s: load at %h expected %h actual %h",
                 cur_test, pend_addr, exp_data, mem_data);
        cmp_errors++;
      end
    end
    if (!rst && inst_valid) begin
      exp_data = expect_load(ld_hot(mem_pkg::LOAD_LWU), exp_pc);
      exp_inst = exp_data[31:0];
      cmp_checks += 2;
      assert (inst_pc === exp_pc) else begin
        $display("ERROR %s: inst_pc expected %h actual %h", cur_test, exp_pc, inst_pc);
        cmp_errors++;
      end
      assert (inst === exp_inst) else begin
        $display("ERROR %s: inst at %h expected %h actual %h",
                 cur_test, exp_pc, exp_inst, inst);
        cmp_errors++;
      end
      exp_pc = exp_pc + 64'd4;
      inst_cnt++;
    end
  end

  task automatic issue(input logic wr, input mem_pkg::load_info_t li,
                       input mem_pkg::save_info_t si, input mem_pkg::addr_t addr,
                       input mem_pkg::reg_t data);
    @(posedge clk);
    pend_load  = !wr;
    pend_info  = li;
    pend_addr  = addr;
    refresh    <= 1'b1;
    ram_wr_ena <= wr;
    ram_rd_ena <= !wr;
    load_info  <= li;
    save_info  <= si;
    mem_addr   <= addr;
    ram_wr_src <= data;
    @(posedge clk);
    refresh <= 1'b0;
  endtask

  task automatic wait_fetched();
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk);
      seen = mem_fetched;
      n++;
    end
    drv_checks++;
    assert (seen) else begin
      $display("%s: mem_fetched did not arrive within %0d cycles", cur_test, TIMEOUT);
      drv_errors++;
    end
  endtask

  task automatic store(input int nbytes, input mem_pkg::addr_t addr, input mem_pkg::reg_t data);
    int i;
    issue(1'b1, '0, st_hot(nbytes), addr, data);
    wait_fetched();
    for (i = 0; i < nbytes; i++) ref_mem[byte_idx(addr, i)] = data[8*i +: 8];
  endtask

  task automatic load(input int kind, input mem_pkg::addr_t addr);
    issue(1'b0, ld_hot(kind), '0, addr, '0);
    wait_fetched(); // data checked by the compare process
  endtask

  task automatic store_and_load(input int nbytes, input mem_pkg::addr_t addr);
    store(nbytes, addr, rand64());
    case (nbytes)
      1: begin
        load(mem_pkg::LOAD_LB, addr);
        load(mem_pkg::LOAD_LBU, addr);
      end
      2: begin
        load(mem_pkg::LOAD_LH, addr);
        load(mem_pkg::LOAD_LHU, addr);
      end
      4: begin
        load(mem_pkg::LOAD_LW, addr);
        load(mem_pkg::LOAD_LWU, addr);
      end
      default: load(mem_pkg::LOAD_LD, addr);
    endcase
  endtask

  // misaligned access must raise bit b and never complete
  task automatic expect_no_fetch(input int b);
    int             n;
    logic           seen;
    mem_pkg::excp_t exp_excp;
    exp_excp    = '0;
    exp_excp[b] = 1'b1;
    seen        = 1'b0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (mem_fetched) seen = 1'b1;
    end
    drv_checks += 2;
    assert (!seen) else begin
      $display("%s: mem_fetched pulsed for a misaligned access", cur_test);
      drv_errors++;
    end
    assert (mem_excp === exp_excp) else begin
      $display("ERROR %s: mem_excp expected %b actual %b", cur_test, exp_excp, mem_excp);
      drv_errors++;
    end
  endtask

  task automatic wait_insts(input int target);
    int n;
    n = 0;
    while (inst_cnt < target && n < 4 * TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    drv_checks++;
    assert (inst_cnt >= target) else begin
      $display("%s: only %0d of %0d instructions fetched", cur_test, inst_cnt, target);
      drv_errors++;
    end
  endtask

  task automatic stop_fetch();
    int quiet;
    int n;
    @(posedge clk);
    fetch_en <= 1'b0;
    quiet = 0;
    n     = 0;
    while (quiet < 4 && n < TIMEOUT) begin
      @(negedge clk);
      quiet = inst_valid ? 0 : quiet + 1;
      n++;
    end
    drv_checks++;
    assert (quiet >= 4) else begin
      $display("%s: fetch kept running after fetch_en dropped", cur_test);
      drv_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = drv_errors + cmp_errors;
  endtask

  task automatic end_test();
    int n;
    @(posedge clk);
    n = drv_errors + cmp_errors - err_mark;
    if (n == 0) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, n);
  endtask

  initial begin : stimulus
    int             n;
    int             k;
    int             start;
    mem_pkg::addr_t a;
    refresh    <= 1'b0;
    ram_wr_src <= '0;
    load_info  <= '0;
    save_info  <= '0;
    mem_addr   <= '0;
    ram_rd_ena <= 1'b0;
    ram_wr_ena <= 1'b0;
    fetch_en   <= 1'b0;
    n = 0;
    @(posedge clk);
    while (rst && n < 20) begin
      @(posedge clk);
      n++;
    end
    assert (!rst) else begin
      $display("reset was never released");
      drv_errors++;
    end

    begin_test("store_load_widths");
    for (k = 0; k < 6; k++) begin
      store_and_load(8, rand64() & ~64'h7);
      store_and_load(4, rand64() & ~64'h3);
      store_and_load(2, rand64() & ~64'h1);
      store_and_load(1, rand64());
    end
    end_test();

    begin_test("lane_masking");
    for (k = 0; k < 8; k++) begin
      a = rand64() & ~64'h7;
      store(8, a, 64'h0123_4567_89ab_cdef);
      store(1, a + mem_pkg::addr_t'(k), rand64()); // one byte lane
      load(mem_pkg::LOAD_LD, a);
      store(2, a + mem_pkg::addr_t'(2 * (k % 4)), rand64());
      load(mem_pkg::LOAD_LD, a);
    end
    end_test();

    begin_test("misalignment");
    a = rand64() & ~64'h7;
    store(8, a, rand64());
    issue(1'b0, ld_hot(mem_pkg::LOAD_LH), '0, a + 64'd1, '0);
    expect_no_fetch(mem_pkg::EXCP_LOAD_MISALIGN);
    issue(1'b1, '0, st_hot(4), a + 64'd2, rand64());
    expect_no_fetch(mem_pkg::EXCP_STORE_MISALIGN);
    load(mem_pkg::LOAD_LD, a); // memory must be unchanged
    end_test();

    begin_test("inst_fetch");
    for (k = 0; k < 128; k++) store(8, mem_pkg::addr_t'(8 * k), rand64()); // low 1 KiB
    @(posedge clk);
    fetch_en <= 1'b1;
    wait_insts(16);
    end_test();

    begin_test("contention");
    start = inst_cnt;
    for (k = 0; k < 10; k++) begin
      a     = rand64();
      a[10] = 1'b1; // upper 1 KiB, away from fetch
      store_and_load(8, a & ~64'h7);
      store_and_load(2, a & ~64'h1);
      store_and_load(1, a);
    end
    wait_insts(start + 8);
    stop_fetch();
    end_test();

    $display("checks %0d, errors %0d", drv_checks + cmp_checks, drv_errors + cmp_errors);
    if (drv_errors + cmp_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_subsys -f vlog.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure"
  exit 1
fi

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic      clk,
  input  logic      rst,
  mem_bus_if.slave  mem_m,
  mem_bus_if.slave  fetch_m,
  mem_bus_if.master ram_s
);

  mem_pkg::arb_state_e state;
  logic                gnt_mem;
  logic                gnt_fetch;
  logic                handshake;

  // mem_stage wins a tie
  assign gnt_mem   = (state == mem_pkg::ARB_OWN_MEM) ||
                     (state == mem_pkg::ARB_FREE && mem_m.valid);
  assign gnt_fetch = (state == mem_pkg::ARB_OWN_FETCH) ||
                     (state == mem_pkg::ARB_FREE && !mem_m.valid && fetch_m.valid);
  assign handshake = ram_s.valid && ram_s.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::ARB_FREE;
    end else begin
      case (state)
        mem_pkg::ARB_FREE:
          if (gnt_mem && !handshake)
            state <= mem_pkg::ARB_OWN_MEM;
          else if (gnt_fetch && !handshake)
            state <= mem_pkg::ARB_OWN_FETCH;
        mem_pkg::ARB_OWN_MEM,
        mem_pkg::ARB_OWN_FETCH:
          if (handshake) state <= mem_pkg::ARB_FREE;
        default: state <= mem_pkg::ARB_FREE;
      endcase
    end
  end

  assign ram_s.valid  = (gnt_mem && mem_m.valid) || (gnt_fetch && fetch_m.valid);
  assign ram_s.req    = gnt_mem ? mem_m.req    : fetch_m.req;
  assign ram_s.addr   = gnt_mem ? mem_m.addr   : fetch_m.addr;
  assign ram_s.size   = gnt_mem ? mem_m.size   : fetch_m.size;
  assign ram_s.w_data = gnt_mem ? mem_m.w_data : fetch_m.w_data;

  // response path only to the owner
  assign mem_m.ready    = gnt_mem && ram_s.ready;
  assign mem_m.r_data   = gnt_mem ? ram_s.r_data : '0;
  assign mem_m.resp     = gnt_mem ? ram_s.resp : mem_pkg::RESP_OKAY;
  assign fetch_m.ready  = gnt_fetch && ram_s.ready;
  assign fetch_m.r_data = gnt_fetch ? ram_s.r_data : '0;
  assign fetch_m.resp   = gnt_fetch ? ram_s.resp : mem_pkg::RESP_OKAY;

  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    !(mem_m.ready && fetch_m.ready));

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus
);

  mem_pkg::reg_t                 mem [mem_pkg::RAM_WORDS];
  logic [mem_pkg::RAM_IDX_W-1:0] word_idx;
  logic [2:0]                    byte_off;
  logic [7:0]                    size_mask;
  logic [7:0]                    lane_en;
  mem_pkg::reg_t                 wr_shift;
  logic                          ready_q;

  assign word_idx = bus.addr[mem_pkg::RAM_IDX_W+2:3]; // wraps at 2 KiB
  assign byte_off = bus.addr[2:0];

  always_comb begin
    case (bus.size)
      mem_pkg::SIZE_B: size_mask = 8'h01;
      mem_pkg::SIZE_H: size_mask = 8'h03;
      mem_pkg::SIZE_W: size_mask = 8'h0f;
      default:         size_mask = 8'hff;
    endcase
  end

  assign lane_en  = size_mask << byte_off;
  assign wr_shift = bus.w_data << {byte_off, 3'b000};

  // one ready beat after valid is seen
  always_ff @(posedge clk) begin
    if (rst)
      ready_q <= 1'b0;
    else
      ready_q <= bus.valid && !ready_q;
  end

  always_ff @(posedge clk) begin
    if (bus.valid && ready_q && bus.req) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_en[b]) mem[word_idx][8*b +: 8] <= wr_shift[8*b +: 8];
      end
    end
  end

  assign bus.ready  = ready_q;
  assign bus.r_data = mem[word_idx] >> {byte_off, 3'b000};
  assign bus.resp   = mem_pkg::RESP_OKAY;

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetch_en,
  output mem_pkg::inst_t inst,
  output mem_pkg::addr_t inst_pc,
  output logic           inst_valid,
  mem_bus_if.master      bus
);

  mem_pkg::fetch_state_e state;
  mem_pkg::addr_t        pc;
  logic                  handshake;

  assign handshake = bus.valid && bus.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::FETCH_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        mem_pkg::FETCH_IDLE:
          if (fetch_en) state <= mem_pkg::FETCH_REQ;
        mem_pkg::FETCH_REQ:
          if (handshake) begin
            pc <= pc + 64'd4; // sequential only
            if (!fetch_en) state <= mem_pkg::FETCH_IDLE;
          end
        default: state <= mem_pkg::FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      inst_valid <= 1'b0;
    else
      inst_valid <= handshake;
  end

  always_ff @(posedge clk) begin
    if (handshake) begin
      inst    <= bus.r_data[31:0];
      inst_pc <= pc;
    end
  end

  assign bus.valid  = (state == mem_pkg::FETCH_REQ);
  assign bus.req    = 1'b0;
  assign bus.addr   = pc;
  assign bus.size   = mem_pkg::SIZE_W;
  assign bus.w_data = '0;

  a_addr_hold: assert property (@(posedge clk) disable iff (rst)
    (bus.valid && !bus.ready) |=> (bus.valid && $stable(bus.addr)));

endmodule

//--- verilog/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

  logic            valid;
  logic            ready;
  logic            req;    // 1 = write
  mem_pkg::addr_t  addr;
  mem_pkg::reg_t   w_data; // low bytes hold store data
  mem_pkg::size_t  size;
  mem_pkg::reg_t   r_data; // low bytes hold load data
  mem_pkg::resp_t  resp;

  modport master (
    output valid, req, addr, w_data, size,
    input  ready, r_data, resp
  );

  modport slave (
    input  valid, req, addr, w_data, size,
    output ready, r_data, resp
  );

endinterface

//--- verilog/mem_pkg.sv
package mem_pkg;

  localparam int XLEN     = 64;
  localparam int INST_LEN = 32;
  localparam int LOAD_N   = 7;
  localparam int SAVE_N   = 4;
  localparam int EXCP_N   = 2;

  typedef logic [XLEN-1:0]     reg_t;
  typedef logic [INST_LEN-1:0] inst_t;
  typedef logic [XLEN-1:0]     addr_t;
  typedef logic [LOAD_N-1:0]   load_info_t;
  typedef logic [SAVE_N-1:0]   save_info_t;
  typedef logic [1:0]          size_t;
  typedef logic [1:0]          resp_t;
  typedef logic [EXCP_N-1:0]   excp_t;

  // load one-hot bit positions
  localparam int LOAD_LB  = 0;
  localparam int LOAD_LH  = 1;
  localparam int LOAD_LW  = 2;
  localparam int LOAD_LD  = 3;
  localparam int LOAD_LBU = 4;
  localparam int LOAD_LHU = 5;
  localparam int LOAD_LWU = 6;

  // store one-hot bit positions
  localparam int SAVE_SB = 0;
  localparam int SAVE_SH = 1;
  localparam int SAVE_SW = 2;
  localparam int SAVE_SD = 3;

  localparam size_t SIZE_B = 2'd0; // 1 byte
  localparam size_t SIZE_H = 2'd1; // 2 bytes
  localparam size_t SIZE_W = 2'd2; // 4 bytes
  localparam size_t SIZE_D = 2'd3; // 8 bytes

  localparam resp_t RESP_OKAY = 2'd0;

  localparam int EXCP_LOAD_MISALIGN  = 0;
  localparam int EXCP_STORE_MISALIGN = 1;

  // 256 x 64 bit, 2 KiB of byte space
  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);

  typedef enum logic {
    MEM_IDLE,
    MEM_ADDR
  } mem_state_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_REQ
  } fetch_state_e;

  typedef enum logic [1:0] {
    ARB_FREE,
    ARB_OWN_MEM,
    ARB_OWN_FETCH
  } arb_state_e;

endpackage

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                refresh,
  input  mem_pkg::reg_t       ram_wr_src,
  input  mem_pkg::load_info_t load_info,
  input  mem_pkg::save_info_t save_info,
  input  mem_pkg::addr_t      mem_addr,
  input  logic                ram_rd_ena,
  input  logic                ram_wr_ena,
  output mem_pkg::reg_t       mem_data,
  output mem_pkg::excp_t      mem_excp,
  output logic                mem_fetched,
  mem_bus_if.master           bus
);

  mem_pkg::mem_state_e state;
  mem_pkg::size_t      acc_size;
  mem_pkg::reg_t       st_mask;
  mem_pkg::reg_t       ld_ext;
  logic                misalign;
  logic                access;
  logic                handshake;

  assign access    = ram_rd_ena || ram_wr_ena;
  assign handshake = bus.valid && bus.ready;

  always_comb begin
    acc_size = mem_pkg::SIZE_D;
    if (ram_wr_ena) begin
      if (save_info[mem_pkg::SAVE_SB])
        acc_size = mem_pkg::SIZE_B;
      else if (save_info[mem_pkg::SAVE_SH])
        acc_size = mem_pkg::SIZE_H;
      else if (save_info[mem_pkg::SAVE_SW])
        acc_size = mem_pkg::SIZE_W;
    end else begin
      if (load_info[mem_pkg::LOAD_LB] || load_info[mem_pkg::LOAD_LBU])
        acc_size = mem_pkg::SIZE_B;
      else if (load_info[mem_pkg::LOAD_LH] || load_info[mem_pkg::LOAD_LHU])
        acc_size = mem_pkg::SIZE_H;
      else if (load_info[mem_pkg::LOAD_LW] || load_info[mem_pkg::LOAD_LWU])
        acc_size = mem_pkg::SIZE_W;
    end
  end

  always_comb begin
    case (acc_size)
      mem_pkg::SIZE_B: st_mask = 64'h0000_0000_0000_00ff;
      mem_pkg::SIZE_H: st_mask = 64'h0000_0000_0000_ffff;
      mem_pkg::SIZE_W: st_mask = 64'h0000_0000_ffff_ffff;
      default:         st_mask = '1;
    endcase
  end

  // natural alignment per access size
  always_comb begin
    case (acc_size)
      mem_pkg::SIZE_H: misalign = mem_addr[0];
      mem_pkg::SIZE_W: misalign = |mem_addr[1:0];
      mem_pkg::SIZE_D: misalign = |mem_addr[2:0];
      default:         misalign = 1'b0;
    endcase
  end

  always_comb begin
    if (load_info[mem_pkg::LOAD_LB])
      ld_ext = {{56{bus.r_data[7]}}, bus.r_data[7:0]};
    else if (load_info[mem_pkg::LOAD_LH])
      ld_ext = {{48{bus.r_data[15]}}, bus.r_data[15:0]};
    else if (load_info[mem_pkg::LOAD_LW])
      ld_ext = {{32{bus.r_data[31]}}, bus.r_data[31:0]};
    else if (load_info[mem_pkg::LOAD_LBU])
      ld_ext = {56'b0, bus.r_data[7:0]};
    else if (load_info[mem_pkg::LOAD_LHU])
      ld_ext = {48'b0, bus.r_data[15:0]};
    else if (load_info[mem_pkg::LOAD_LWU])
      ld_ext = {32'b0, bus.r_data[31:0]};
    else
      ld_ext = bus.r_data; // LD
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::MEM_IDLE;
    end else begin
      case (state)
        mem_pkg::MEM_IDLE:
          if (refresh && access && !misalign) state <= mem_pkg::MEM_ADDR;
        mem_pkg::MEM_ADDR:
          if (handshake) state <= mem_pkg::MEM_IDLE;
        default: state <= mem_pkg::MEM_IDLE;
      endcase
    end
  end

  // exception holds until the next refresh
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_excp <= '0;
    end else if (refresh) begin
      mem_excp <= '0;
      if (access && misalign) begin
        if (ram_wr_ena)
          mem_excp[mem_pkg::EXCP_STORE_MISALIGN] <= 1'b1;
        else
          mem_excp[mem_pkg::EXCP_LOAD_MISALIGN] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      mem_fetched <= 1'b0;
    else
      mem_fetched <= handshake;
  end

  always_ff @(posedge clk) begin
    if (handshake && !bus.req) mem_data <= ld_ext;
  end

  assign bus.valid  = (state == mem_pkg::MEM_ADDR);
  assign bus.req    = ram_wr_ena;
  assign bus.addr   = mem_addr;
  assign bus.size   = acc_size;
  assign bus.w_data = ram_wr_src & st_mask;

  a_onehot: assert property (@(posedge clk) disable iff (rst)
    (refresh && access) |-> ($onehot0(load_info) && $onehot0(save_info)));

  // the RAM behind the arbiter never reports an error
  a_resp_okay: assert property (@(posedge clk) disable iff (rst)
    handshake |-> (bus.resp == mem_pkg::RESP_OKAY));

endmodule

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                refresh,
  input  mem_pkg::reg_t       ram_wr_src,
  input  mem_pkg::load_info_t load_info,
  input  mem_pkg::save_info_t save_info,
  input  mem_pkg::addr_t      mem_addr,
  input  logic                ram_rd_ena,
  input  logic                ram_wr_ena,
  output mem_pkg::reg_t       mem_data,
  output mem_pkg::excp_t      mem_excp,
  output logic                mem_fetched,
  input  logic                fetch_en,
  output mem_pkg::inst_t      inst,
  output mem_pkg::addr_t      inst_pc,
  output logic                inst_valid
);

  mem_bus_if mem_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if ram_bus ();

  mem_stage u_mem_stage (
    .clk         (clk),
    .rst         (rst),
    .refresh     (refresh),
    .ram_wr_src  (ram_wr_src),
    .load_info   (load_info),
    .save_info   (save_info),
    .mem_addr    (mem_addr),
    .ram_rd_ena  (ram_rd_ena),
    .ram_wr_ena  (ram_wr_ena),
    .mem_data    (mem_data),
    .mem_excp    (mem_excp),
    .mem_fetched (mem_fetched),
    .bus         (mem_bus.master)
  );

  fetch_stage u_fetch_stage (
    .clk        (clk),
    .rst        (rst),
    .fetch_en   (fetch_en),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid),
    .bus        (fetch_bus.master)
  );

  bus_arbiter u_bus_arbiter (
    .clk     (clk),
    .rst     (rst),
    .mem_m   (mem_bus.slave),
    .fetch_m (fetch_bus.slave),
    .ram_s   (ram_bus.master)
  );

  data_ram u_data_ram (
    .clk (clk),
    .rst (rst),
    .bus (ram_bus.slave)
  );

endmodule

//--- vlog.f
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_stage.sv
verilog/fetch_stage.sv
verilog/bus_arbiter.sv
verilog/data_ram.sv
verilog/mem_subsys_top.sv
bench/tb_clock_gen.sv
bench/tb_mem_subsys.sv
